/* sources.f */
logic/ucnt_pkg.sv
logic/ctrl_if.sv
logic/wb_regs.sv
logic/cmd_fifo.sv
logic/io_counter.sv
logic/user_counter_top.sv
bench/tb_clkgen.sv
bench/tb_user_counter.sv

/* Makefile */
# Verilator flow for the user-area counter
# Override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR  ?= verilator
TOP        ?= tb_user_counter
FILELIST   ?= sources.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
VFLAGS     ?= --binary --timing --assert -Wno-fatal
SIM_ARGS   ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Exit status of the simulation binary is the pass or fail result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

/* bench/tb_user_counter.sv */
// ============================
// Wishbone tasks, counter model,
// per-cycle checker and test sequence
// ============================
`timescale 1ns/1ps
`default_nettype none

module tb_user_counter;

   // Cycle limits for the wait loops
   localparam int ACK_TIMEOUT = 16;
   localparam int RST_TIMEOUT = 64;
   localparam int WRAP_TIMEOUT = 128;

   logic clk;
   logic arst_n;

   // DUT inputs idle from time zero
   logic                              stb = 1'b0;
   logic                              cyc = 1'b0;
   logic                              we = 1'b0;
   logic [ucnt_pkg::WB_W-1:0]         adr = '0;
   logic [ucnt_pkg::WB_W-1:0]         dat = '0;

   // DUT outputs
   logic                              ack;
   logic [ucnt_pkg::WB_W-1:0]         rdat;
   logic [ucnt_pkg::CNT_W-1:0]        io_out;
   logic [ucnt_pkg::CNT_W-1:0]        io_oeb;
   logic [ucnt_pkg::LA_W-1:0]         la_data;
   logic [ucnt_pkg::IRQ_W-1:0]        irq;

   // Model state
   logic [ucnt_pkg::CNT_W-1:0]        m_queue [$];
   logic [ucnt_pkg::CNT_W-1:0]        m_count = '0;
   logic                              m_en = 1'b0;
   logic                              m_irq_en = 1'b0;
   logic                              m_restart = 1'b0;
   logic                              m_irq = 1'b0;
   logic                              m_oeb = 1'b1;
   // Queue length as it stood before the last edge
   int unsigned                       m_len_before = 0;

   // Bookkeeping
   int unsigned                       edge_cnt = 0;
   int unsigned                       wrap_cnt = 0;
   int unsigned                       irq_cnt = 0;
   int unsigned                       ack_edge = 0;
   logic [ucnt_pkg::CNT_W-1:0]        ack_count = '0;
   integer                            seed = 32'h931e;

   tb_clkgen u_clkgen (
      .clk_o    (clk),
      .arst_n_o (arst_n)
   );

   user_counter_top u_user_counter_top (
      .wb_clk_i  (clk),
      .arst_n_i  (arst_n),
      .wbs_stb_i (stb),
      .wbs_cyc_i (cyc),
      .wbs_we_i  (we),
      .wbs_adr_i (adr),
      .wbs_dat_i (dat),
      .wbs_ack_o (ack),
      .wbs_dat_o (rdat),
      .io_out_o  (io_out),
      .io_oeb_o  (io_oeb),
      .la_data_o (la_data),
      .irq_o     (irq)
   );

   // Next count by priority of restart, terminal count, enable and hold
   function automatic logic [ucnt_pkg::CNT_W-1:0] ref_next_count(
      input  logic [ucnt_pkg::CNT_W-1:0] count,
      input  logic                       en,
      input  logic                       restart,
      input  logic                       q_empty,
      input  logic [ucnt_pkg::CNT_W-1:0] q_head,
      output logic                       take,
      output logic                       wrap
   );
      logic [ucnt_pkg::CNT_W-1:0] reload;
      logic [ucnt_pkg::CNT_W-1:0] nxt;
      // Empty queue falls back to zero
      reload = q_empty ? '0 : q_head;
      take = 1'b0;
      wrap = 1'b0;
      nxt = count;
      if (restart) begin
         take = 1'b1;
         nxt = reload;
      end else if (en && count == '1) begin
         take = 1'b1;
         wrap = 1'b1;
         nxt = reload;
      end else if (en) begin
         nxt = count + 1'b1;
      end
      return nxt;
   endfunction

   function automatic logic [ucnt_pkg::WB_W-1:0] reg_addr(
      input logic [ucnt_pkg::ADR_W-1:0] reg_sel
   );
      logic [ucnt_pkg::WB_W-1:0] a;
      a = '0;
      a[ucnt_pkg::ADR_LSB +: ucnt_pkg::ADR_W] = reg_sel;
      return a;
   endfunction

   function automatic logic [ucnt_pkg::WB_W-1:0] ctrl_data(
      input logic en,
      input logic irq_en,
      input logic restart,
      input logic ovf_clr
   );
      ucnt_pkg::ctrl_word_t cw;
      cw = '0;
      cw.enable = en;
      cw.irq_en = irq_en;
      cw.restart = restart;
      cw.ovf_clr = ovf_clr;
      return cw;
   endfunction

   // Reload value zero-extended to a bus word
   function automatic logic [ucnt_pkg::WB_W-1:0] load_data(
      input logic [ucnt_pkg::CNT_W-1:0] v
   );
      logic [ucnt_pkg::WB_W-1:0] d;
      d = '0;
      d[ucnt_pkg::CNT_W-1:0] = v;
      return d;
   endfunction

   // STATUS word for a given queue length and overflow flag
   function automatic logic [ucnt_pkg::WB_W-1:0] status_exp(
      input int unsigned len,
      input logic        ovf
   );
      logic [ucnt_pkg::WB_W-1:0] st;
      st = '0;
      st[ucnt_pkg::ST_LVL_LSB +: ucnt_pkg::LVL_W] = len[ucnt_pkg::LVL_W-1:0];
      st[ucnt_pkg::ST_FULL] = (len == ucnt_pkg::FIFO_DEPTH);
      st[ucnt_pkg::ST_EMPTY] = (len == 0);
      st[ucnt_pkg::ST_OVF] = ovf;
      return st;
   endfunction

   function automatic logic [ucnt_pkg::CNT_W-1:0] rand_value();
      logic [31:0] r;
      r = $random(seed);
      return r[ucnt_pkg::CNT_W-1:0];
   endfunction

   task automatic stop_failed();
      $display("Test FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_count(
      input string                      name,
      input logic [ucnt_pkg::CNT_W-1:0] exp,
      input logic [ucnt_pkg::CNT_W-1:0] act
   );
      if (act !== exp) begin
         $display("ERR time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
         stop_failed();
      end
   endtask

   task automatic check_word(
      input string                     name,
      input logic [ucnt_pkg::WB_W-1:0] exp,
      input logic [ucnt_pkg::WB_W-1:0] act
   );
      if (act !== exp) begin
         $display("ERR time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
         stop_failed();
      end
   endtask

   task automatic check_bit(
      input string name,
      input logic  exp,
      input logic  act
   );
      if (act !== exp) begin
         $display("ERR time=%0t signal=%s expected=%b actual=%b", $time, name, exp, act);
         stop_failed();
      end
   endtask

   // Model step at every rising edge
   always @(posedge clk) begin : model_step
      logic                       take;
      logic                       wrap;
      logic [ucnt_pkg::CNT_W-1:0] head;
      logic [ucnt_pkg::CNT_W-1:0] nxt;
      edge_cnt = edge_cnt + 1;
      m_len_before = m_queue.size();
      if (!arst_n) begin
         m_count = '0;
         m_irq = 1'b0;
         m_oeb = 1'b1;
         m_restart = 1'b0;
      end else begin
         head = (m_queue.size() > 0) ? m_queue[0] : '0;
         nxt = ref_next_count(m_count, m_en, m_restart, m_queue.size() == 0, head, take, wrap);
         if (take && m_queue.size() > 0) begin
            m_queue.delete(0);
         end
         // Irq follows wrap when irq_en is set
         m_irq = wrap & m_irq_en;
         if (wrap) begin
            wrap_cnt = wrap_cnt + 1;
         end
         m_count = nxt;
         m_restart = 1'b0;
         m_oeb = 1'b0;
      end
   end

   // Outputs are stable at the falling edge
   always @(negedge clk) begin
      // Model holds no state before the first rising edge
      if (edge_cnt > 0) begin
         check_count("io_out_o", m_count, io_out);
         check_count("io_oeb_o", {ucnt_pkg::CNT_W{m_oeb}}, io_oeb);
         check_count("la_data_o[15:0]", m_count, la_data[ucnt_pkg::CNT_W-1:0]);
         check_bit("la_data_o upper bits", 1'b0, |la_data[ucnt_pkg::LA_W-1:ucnt_pkg::CNT_W]);
         check_bit("irq_o[0]", m_irq, irq[0]);
         check_bit("irq_o[2:1]", 1'b0, |irq[ucnt_pkg::IRQ_W-1:1]);
         if (!arst_n) begin
            check_bit("wbs_ack_o", 1'b0, ack);
         end
         if (irq[0]) begin
            irq_cnt = irq_cnt + 1;
         end
      end
   end

   // Write lands in the model between the ack edge and the next one
   task automatic model_write(
      input logic [ucnt_pkg::ADR_W-1:0] reg_sel,
      input logic [ucnt_pkg::WB_W-1:0]  data
   );
      ucnt_pkg::ctrl_word_t cw;
      cw = data;
      if (reg_sel == ucnt_pkg::REG_CTRL) begin
         m_en = cw.enable;
         m_irq_en = cw.irq_en;
         m_restart = cw.restart;
      end else if (reg_sel == ucnt_pkg::REG_LOAD) begin
         // Full FIFO drops the value
         if (m_len_before < ucnt_pkg::FIFO_DEPTH) begin
            m_queue.push_back(data[ucnt_pkg::CNT_W-1:0]);
         end
      end
   endtask

   task automatic wait_ack(input string what);
      int waited;
      waited = 0;
      do begin
         @(negedge clk);
         waited = waited + 1;
         if (waited > ACK_TIMEOUT) begin
            $display("Timeout: no Wishbone ack on %s", what);
            stop_failed();
         end
      end while (!ack);
   endtask

   task automatic wb_write(
      input logic [ucnt_pkg::ADR_W-1:0] reg_sel,
      input logic [ucnt_pkg::WB_W-1:0]  data
   );
      @(posedge clk);
      cyc <= 1'b1;
      stb <= 1'b1;
      we <= 1'b1;
      adr <= reg_addr(reg_sel);
      dat <= data;
      wait_ack("write");
      ack_edge = edge_cnt;
      ack_count = m_count;
      model_write(reg_sel, data);
      // Drop the request in the cycle after ack
      @(posedge clk);
      cyc <= 1'b0;
      stb <= 1'b0;
      we <= 1'b0;
   endtask

   task automatic wb_read(
      input  logic [ucnt_pkg::ADR_W-1:0] reg_sel,
      output logic [ucnt_pkg::WB_W-1:0]  data
   );
      @(posedge clk);
      cyc <= 1'b1;
      stb <= 1'b1;
      we <= 1'b0;
      adr <= reg_addr(reg_sel);
      dat <= '0;
      wait_ack("read");
      data = rdat;
      @(posedge clk);
      cyc <= 1'b0;
      stb <= 1'b0;
   endtask

   // Reset only changes between rising edges
   task automatic wait_for_reset();
      int waited;
      waited = 0;
      do begin
         @(posedge clk);
         waited = waited + 1;
         if (waited > RST_TIMEOUT) begin
            $display("Timeout: reset was never released");
            stop_failed();
         end
      end while (arst_n !== 1'b1);
   endtask

   // Returns at the first falling edge after the target wrap count
   task automatic wait_wraps(input int unsigned target);
      int waited;
      waited = 0;
      while (wrap_cnt < target) begin
         @(negedge clk);
         waited = waited + 1;
         if (waited > WRAP_TIMEOUT) begin
            $display("Timeout: counter did not reach terminal count");
            stop_failed();
         end
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   initial begin : test_main
      logic [ucnt_pkg::CNT_W-1:0] v0;
      logic [ucnt_pkg::CNT_W-1:0] v1;
      logic [ucnt_pkg::CNT_W-1:0] near;
      logic [ucnt_pkg::CNT_W-1:0] last;
      logic [ucnt_pkg::CNT_W-1:0] span_start;
      logic [ucnt_pkg::CNT_W-1:0] vals [ucnt_pkg::FIFO_DEPTH+1];
      logic [ucnt_pkg::WB_W-1:0]  rd;
      int unsigned                start_edge;
      int unsigned                span_edges;
      int unsigned                wraps0;
      int unsigned                irq0;

      wait_for_reset();
      idle_cycles(2);

      // Restart from the queue with the counter stopped
      v0 = rand_value();
      v1 = rand_value();
      wb_write(ucnt_pkg::REG_LOAD, load_data(v0));
      wb_write(ucnt_pkg::REG_LOAD, load_data(v1));
      wb_write(ucnt_pkg::REG_CTRL, ctrl_data(1'b0, 1'b0, 1'b1, 1'b0));
      @(negedge clk);
      check_count("io_out_o after restart", v0, io_out);
      wb_read(ucnt_pkg::REG_COUNT, rd);
      check_word("COUNT", load_data(v0), rd);
      wb_read(ucnt_pkg::REG_STATUS, rd);
      check_word("STATUS", status_exp(1, 1'b0), rd);

      // Drain v1 and run through two terminal counts
      wb_write(ucnt_pkg::REG_CTRL, ctrl_data(1'b0, 1'b0, 1'b1, 1'b0));
      @(negedge clk);
      check_count("io_out_o after restart", v1, io_out);
      near = {{(ucnt_pkg::CNT_W-4){1'b1}}, 4'h7};
      last = rand_value() | {{(ucnt_pkg::CNT_W-4){1'b1}}, 4'h0};
      wraps0 = wrap_cnt;
      irq0 = irq_cnt;
      wb_write(ucnt_pkg::REG_LOAD, load_data(near));
      wb_write(ucnt_pkg::REG_LOAD, load_data(last));
      wb_write(ucnt_pkg::REG_CTRL, ctrl_data(1'b1, 1'b1, 1'b1, 1'b0));
      wait_wraps(wraps0 + 2);
      // Queue is empty by now so the second wrap lands on zero
      check_count("io_out_o at empty wrap", '0, io_out);
      wb_write(ucnt_pkg::REG_CTRL, ctrl_data(1'b0, 1'b0, 1'b0, 1'b0));
      idle_cycles(2);
      check_bit("irq pulse at each wrap", 1'b1, irq_cnt == irq0 + 2);

      // Count grows by the edges between the enable and disable acks
      wb_write(ucnt_pkg::REG_CTRL, ctrl_data(1'b1, 1'b0, 1'b0, 1'b0));
      span_start = ack_count;
      start_edge = ack_edge;
      idle_cycles(9);
      wb_write(ucnt_pkg::REG_CTRL, ctrl_data(1'b0, 1'b0, 1'b0, 1'b0));
      span_edges = ack_edge - start_edge;
      idle_cycles(2);
      check_count("io_out_o after enable span",
                  span_start + span_edges[ucnt_pkg::CNT_W-1:0], io_out);
      idle_cycles(6);
      check_count("io_out_o held after disable",
                  span_start + span_edges[ucnt_pkg::CNT_W-1:0], io_out);

      // One load more than the FIFO holds
      for (int i = 0; i <= ucnt_pkg::FIFO_DEPTH; i++) begin
         vals[i] = rand_value();
         wb_write(ucnt_pkg::REG_LOAD, load_data(vals[i]));
      end
      wb_read(ucnt_pkg::REG_STATUS, rd);
      check_word("STATUS after overflow", status_exp(ucnt_pkg::FIFO_DEPTH, 1'b1), rd);
      wb_write(ucnt_pkg::REG_CTRL, ctrl_data(1'b0, 1'b0, 1'b0, 1'b1));
      wb_read(ucnt_pkg::REG_STATUS, rd);
      check_word("STATUS after overflow clear", status_exp(ucnt_pkg::FIFO_DEPTH, 1'b0), rd);
      for (int i = 0; i < ucnt_pkg::FIFO_DEPTH; i++) begin
         wb_write(ucnt_pkg::REG_CTRL, ctrl_data(1'b0, 1'b0, 1'b1, 1'b0));
         @(negedge clk);
         check_count("io_out_o queued value", vals[i], io_out);
      end
      // Fifth value was dropped so the queue falls back to zero
      wb_write(ucnt_pkg::REG_CTRL, ctrl_data(1'b0, 1'b0, 1'b1, 1'b0));
      @(negedge clk);
      check_count("io_out_o after dropped load", '0, io_out);
      wb_read(ucnt_pkg::REG_STATUS, rd);
      check_word("STATUS after drain", status_exp(0, 1'b0), rd);

      // Terminal reload with irq_en clear
      irq0 = irq_cnt;
      wraps0 = wrap_cnt;
      near = {{(ucnt_pkg::CNT_W-4){1'b1}}, 4'ha};
      v0 = rand_value();
      wb_write(ucnt_pkg::REG_LOAD, load_data(near));
      wb_write(ucnt_pkg::REG_LOAD, load_data(v0));
      wb_write(ucnt_pkg::REG_CTRL, ctrl_data(1'b1, 1'b0, 1'b1, 1'b0));
      wait_wraps(wraps0 + 1);
      check_count("io_out_o after gated wrap", v0, io_out);
      wb_write(ucnt_pkg::REG_CTRL, ctrl_data(1'b0, 1'b0, 1'b0, 1'b0));
      idle_cycles(2);
      check_bit("irq_o held low with irq_en clear", 1'b1, irq_cnt == irq0);

      idle_cycles(4);
      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

/* bench/tb_clkgen.sv */
// ============================
// Testbench clock and reset source
// ============================
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
   output logic clk_o,
   output logic arst_n_o
);

   localparam int RST_CYCLES = 10;

   // 8 ns period
   initial begin
      clk_o = 1'b0;
      forever #4 clk_o = ~clk_o;
   end

   // Start high so the DUT sees a real falling edge on reset
   initial begin
      arst_n_o = 1'b1;
      #1;
      arst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      // Release between edges
      @(negedge clk_o);
      arst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

/* logic/user_counter_top.sv */
// ============================
// User-area counter top: Wishbone,
// GPIO, LA and IRQ ports
// ============================
`timescale 1ns/1ps
`default_nettype none

module user_counter_top (
   input  wire                              wb_clk_i,
   input  wire                              arst_n_i,
   // Wishbone classic slave, full-word accesses only
   input  wire                              wbs_stb_i,
   input  wire                              wbs_cyc_i,
   input  wire                              wbs_we_i,
   input  wire  [ucnt_pkg::WB_W-1:0]        wbs_adr_i,
   input  wire  [ucnt_pkg::WB_W-1:0]        wbs_dat_i,
   output logic                             wbs_ack_o,
   output logic [ucnt_pkg::WB_W-1:0]        wbs_dat_o,
   // GPIO
   output logic [ucnt_pkg::CNT_W-1:0]       io_out_o,
   output logic [ucnt_pkg::CNT_W-1:0]       io_oeb_o,
   // Logic analyzer mirror of the count
   output logic [ucnt_pkg::LA_W-1:0]        la_data_o,
   // Only bit 0 is used
   output logic [ucnt_pkg::IRQ_W-1:0]       irq_o
);

   // FIFO write side
   logic                         push;
   logic [ucnt_pkg::CNT_W-1:0]   push_data;
   logic                         full;
   logic [ucnt_pkg::LVL_W-1:0]   level;
   // FIFO read side
   logic                         pop;
   logic [ucnt_pkg::CNT_W-1:0]   head;
   logic                         empty;
   logic                         cnt_irq;

   ctrl_if ctrl_bus ();

   // Producer
   wb_regs u_wb_regs (
      .wb_clk_i    (wb_clk_i),
      .arst_n_i    (arst_n_i),
      .wbs_stb_i   (wbs_stb_i),
      .wbs_cyc_i   (wbs_cyc_i),
      .wbs_we_i    (wbs_we_i),
      .wbs_adr_i   (wbs_adr_i),
      .wbs_dat_i   (wbs_dat_i),
      .wbs_ack_o   (wbs_ack_o),
      .wbs_dat_o   (wbs_dat_o),
      .push_o      (push),
      .push_data_o (push_data),
      .full_i      (full),
      .level_i     (level),
      .ctrl        (ctrl_bus.regs)
   );

   // Reload queue
   cmd_fifo u_cmd_fifo (
      .wb_clk_i    (wb_clk_i),
      .arst_n_i    (arst_n_i),
      .push_i      (push),
      .push_data_i (push_data),
      .pop_i       (pop),
      .head_o      (head),
      .empty_o     (empty),
      .full_o      (full),
      .level_o     (level)
   );

   // Consumer
   io_counter u_io_counter (
      .wb_clk_i (wb_clk_i),
      .arst_n_i (arst_n_i),
      .head_i   (head),
      .empty_i  (empty),
      .pop_o    (pop),
      .io_out_o (io_out_o),
      .io_oeb_o (io_oeb_o),
      .irq_o    (cnt_irq),
      .ctrl     (ctrl_bus.cnt)
   );

   // Count zero-extended onto the LA outputs
   assign la_data_o = {{(ucnt_pkg::LA_W - ucnt_pkg::CNT_W){1'b0}}, ctrl_bus.count};

   // Upper interrupt lines unused
   assign irq_o = {{(ucnt_pkg::IRQ_W - 1){1'b0}}, cnt_irq};

endmodule

`default_nettype wire

/* logic/io_counter.sv */
// ============================
// Counter with FIFO reload, restart,
// wrap interrupt and output enables
// ============================
`timescale 1ns/1ps
`default_nettype none

module io_counter (
   input  wire                              wb_clk_i,
   input  wire                              arst_n_i,
   // Reload FIFO read side
   input  wire  [ucnt_pkg::CNT_W-1:0]       head_i,
   input  wire                              empty_i,
   output logic                             pop_o,
   // Pads
   output logic [ucnt_pkg::CNT_W-1:0]       io_out_o,
   output logic [ucnt_pkg::CNT_W-1:0]       io_oeb_o,
   // Wrap interrupt gated by irq_en
   output logic                             irq_o,
   // Control from the register block
   ctrl_if.cnt                              ctrl
);

   logic [ucnt_pkg::CNT_W-1:0] count_q;
   logic [ucnt_pkg::CNT_W-1:0] reload;
   logic                       tc;
   logic                       take_tc;
   logic                       take;
   logic                       wrap_q;
   logic                       irq_q;
   logic                       oeb_q;

   // Terminal count is all ones
   assign tc = &count_q;

   // Restart wins over terminal count
   assign take_tc = ctrl.enable & tc & ~ctrl.restart;
   assign take = ctrl.restart | take_tc;

   // Empty queue reloads zero
   assign reload = empty_i ? '0 : head_i;

   // Pop exactly when a queued value is consumed
   assign pop_o = take & ~empty_i;

   always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         count_q <= '0;
         wrap_q <= 1'b0;
         irq_q <= 1'b0;
         // Pads stay tristated while in reset
         oeb_q <= 1'b1;
      end else begin
         oeb_q <= 1'b0;
         // Wrap marks terminal reloads only
         wrap_q <= take_tc;
         irq_q <= take_tc & ctrl.irq_en;
         if (take) begin
            count_q <= reload;
         end else if (ctrl.enable) begin
            count_q <= count_q + 1'b1;
         end
      end
   end

   assign ctrl.count = count_q;
   assign ctrl.wrap = wrap_q;

   assign io_out_o = count_q;
   assign io_oeb_o = {ucnt_pkg::CNT_W{oeb_q}};
   assign irq_o = irq_q;

   // FIFO status must agree with what the counter consumes
   a_pop_nonempty: assert property (
      @(posedge wb_clk_i) disable iff (!arst_n_i)
      pop_o |-> !empty_i
   );

endmodule

`default_nettype wire

/* logic/cmd_fifo.sv */
// ============================
// Reload-value FIFO with level,
// full and empty flags
// ============================
`timescale 1ns/1ps
`default_nettype none

module cmd_fifo (
   input  wire                              wb_clk_i,
   input  wire                              arst_n_i,
   // Write side from the register block
   input  wire                              push_i,
   input  wire  [ucnt_pkg::CNT_W-1:0]       push_data_i,
   // Read side towards the counter
   input  wire                              pop_i,
   output logic [ucnt_pkg::CNT_W-1:0]       head_o,
   // Status
   output logic                             empty_o,
   output logic                             full_o,
   output logic [ucnt_pkg::LVL_W-1:0]       level_o
);

   // Storage
   logic [ucnt_pkg::CNT_W-1:0] mem_q [ucnt_pkg::FIFO_DEPTH];

   logic [ucnt_pkg::PTR_W-1:0] wr_ptr_q;
   logic [ucnt_pkg::PTR_W-1:0] rd_ptr_q;
   logic [ucnt_pkg::LVL_W-1:0] level_q;

   always_ff @(posedge wb_clk_i) begin
      if (push_i) begin
         mem_q[wr_ptr_q] <= push_data_i;
      end
   end

   // Pointers and level
   always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         level_q <= '0;
      end else begin
         if (push_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop_i) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // Push and pop together leave the level alone
         case ({push_i, pop_i})
            2'b10: level_q <= level_q + 1'b1;
            2'b01: level_q <= level_q - 1'b1;
            default: level_q <= level_q;
         endcase
      end
   end

   // Head is read without a pop, the counter decides when to take it
   assign head_o = mem_q[rd_ptr_q];

   assign empty_o = (level_q == '0);
   assign full_o = (level_q == ucnt_pkg::LVL_FULL);
   assign level_o = level_q;

   // Register block must drop LOAD writes once full
   a_no_push_full: assert property (
      @(posedge wb_clk_i) disable iff (!arst_n_i)
      push_i |-> !full_o
   );

   // Counter must fall back to zero instead of popping an empty queue
   a_no_pop_empty: assert property (
      @(posedge wb_clk_i) disable iff (!arst_n_i)
      pop_i |-> !empty_o
   );

   a_level_range: assert property (
      @(posedge wb_clk_i) disable iff (!arst_n_i)
      level_q <= ucnt_pkg::LVL_FULL
   );

endmodule

`default_nettype wire

/* logic/wb_regs.sv */
// ============================
// Wishbone slave: CTRL, LOAD, COUNT
// and STATUS registers, overflow flag
// ============================
`timescale 1ns/1ps
`default_nettype none

module wb_regs (
   input  wire                              wb_clk_i,
   input  wire                              arst_n_i,
   // Wishbone classic slave
   input  wire                              wbs_stb_i,
   input  wire                              wbs_cyc_i,
   input  wire                              wbs_we_i,
   input  wire  [ucnt_pkg::WB_W-1:0]        wbs_adr_i,
   input  wire  [ucnt_pkg::WB_W-1:0]        wbs_dat_i,
   output logic                             wbs_ack_o,
   output logic [ucnt_pkg::WB_W-1:0]        wbs_dat_o,
   // Reload FIFO write side
   output logic                             push_o,
   output logic [ucnt_pkg::CNT_W-1:0]       push_data_o,
   input  wire                              full_i,
   input  wire  [ucnt_pkg::LVL_W-1:0]       level_i,
   // Control towards the counter
   ctrl_if.regs                             ctrl
);

   logic                         valid;
   logic                         req;
   logic                         wr_ctrl;
   logic                         wr_load;
   logic [ucnt_pkg::ADR_W-1:0]   word_sel;
   ucnt_pkg::wb_word_u           wdat;
   ucnt_pkg::ctrl_word_t         ctrl_rd;
   logic [ucnt_pkg::WB_W-1:0]    rd_mux;

   logic                         ack_q;
   logic                         enable_q;
   logic                         irq_en_q;
   logic                         restart_q;
   logic                         ovf_q;
   logic [ucnt_pkg::WB_W-1:0]    rd_q;

   // Request is live while both cyc and stb are high
   assign valid = wbs_cyc_i & wbs_stb_i;
   // First cycle of a request, ack goes out on the next edge
   assign req = valid & ~ack_q;

   // Word offset from address bits 3:2
   assign word_sel = wbs_adr_i[ucnt_pkg::ADR_LSB +: ucnt_pkg::ADR_W];

   // Same write word, decoded per target register
   assign wdat = wbs_dat_i;

   assign wr_ctrl = req & wbs_we_i & (word_sel == ucnt_pkg::REG_CTRL);
   assign wr_load = req & wbs_we_i & (word_sel == ucnt_pkg::REG_LOAD);

   // LOAD push lands in the FIFO on the ack edge
   // A full queue drops the value
   assign push_o = wr_load & ~full_i;
   assign push_data_o = wdat.raw[ucnt_pkg::CNT_W-1:0];

   // CTRL readback keeps only the stored levels
   always_comb begin
      ctrl_rd = '0;
      ctrl_rd.enable = enable_q;
      ctrl_rd.irq_en = irq_en_q;
   end

   // Read mux, all fields zero-extended
   always_comb begin
      rd_mux = '0;
      case (word_sel)
         ucnt_pkg::REG_CTRL: begin
            rd_mux = ctrl_rd;
         end
         ucnt_pkg::REG_COUNT: begin
            rd_mux[ucnt_pkg::CNT_W-1:0] = ctrl.count;
         end
         ucnt_pkg::REG_STATUS: begin
            rd_mux[ucnt_pkg::ST_LVL_LSB +: ucnt_pkg::LVL_W] = level_i;
            rd_mux[ucnt_pkg::ST_FULL] = full_i;
            rd_mux[ucnt_pkg::ST_EMPTY] = (level_i == '0);
            rd_mux[ucnt_pkg::ST_OVF] = ovf_q;
         end
         default: begin
            // LOAD is write only
            rd_mux = '0;
         end
      endcase
   end

   // Ack, control levels, restart strobe and overflow
   always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= 1'b0;
         enable_q <= 1'b0;
         irq_en_q <= 1'b0;
         restart_q <= 1'b0;
         ovf_q <= 1'b0;
      end else begin
         // Single-cycle ack, no wait states
         ack_q <= req;
         // Restart high only in the cycle after the ack edge
         restart_q <= wr_ctrl & wdat.ctrl.restart;
         if (wr_ctrl) begin
            enable_q <= wdat.ctrl.enable;
            irq_en_q <= wdat.ctrl.irq_en;
         end
         // Sticky until software clears it
         if (wr_load & full_i) begin
            ovf_q <= 1'b1;
         end else if (wr_ctrl & wdat.ctrl.ovf_clr) begin
            ovf_q <= 1'b0;
         end
      end
   end

   // Read data sampled with the request, valid while ack is high
   always_ff @(posedge wb_clk_i) begin
      if (req & ~wbs_we_i) begin
         rd_q <= rd_mux;
      end else begin
         rd_q <= '0;
      end
   end

   assign wbs_ack_o = ack_q;
   assign wbs_dat_o = rd_q;

   assign ctrl.enable = enable_q;
   assign ctrl.irq_en = irq_en_q;
   assign ctrl.restart = restart_q;

   // Every ack is a lone pulse, so the master sees each access once
   a_ack_single: assert property (
      @(posedge wb_clk_i) disable iff (!arst_n_i)
      wbs_ack_o |=> !wbs_ack_o
   );

endmodule

`default_nettype wire

/* logic/ctrl_if.sv */
// ============================
// Control and status bundle between
// the register block and the counter
// ============================
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if;

   // Levels from the register block
   logic enable;
   logic irq_en;
   // One-cycle restart strobe
   logic restart;

   // Counter state back towards the register block
   logic [ucnt_pkg::CNT_W-1:0] count;
   // High for one cycle after a terminal count reload
   logic wrap;

   // Register block side
   modport regs (
      output enable,
      output irq_en,
      output restart,
      input  count,
      input  wrap
   );

   // Counter side
   modport cnt (
      input  enable,
      input  irq_en,
      input  restart,
      output count,
      output wrap
   );

endinterface

`default_nettype wire

/* logic/ucnt_pkg.sv */
// ============================
// Shared widths, register map, FIFO depth,
// STATUS bit positions and Wishbone word views
// ============================
`default_nettype none

package ucnt_pkg;

   // Counter and reload value width
   localparam int CNT_W = 16;
   // Wishbone data and address width
   localparam int WB_W = 32;
   // Logic analyzer and interrupt port widths
   localparam int LA_W = 128;
   localparam int IRQ_W = 3;

   // Reload queue, pointers wrap naturally at this depth
   localparam int FIFO_DEPTH = 4;
   localparam int PTR_W = 2;
   // Level counts 0 up to FIFO_DEPTH
   localparam int LVL_W = 3;
   localparam logic [LVL_W-1:0] LVL_FULL = LVL_W'(FIFO_DEPTH);

   // Word offsets, taken from address bits 3:2
   localparam int ADR_LSB = 2;
   localparam int ADR_W = 2;
   localparam logic [ADR_W-1:0] REG_CTRL = 2'd0;
   localparam logic [ADR_W-1:0] REG_LOAD = 2'd1;
   localparam logic [ADR_W-1:0] REG_COUNT = 2'd2;
   localparam logic [ADR_W-1:0] REG_STATUS = 2'd3;

   // STATUS layout, level field starts at bit 0
   localparam int ST_LVL_LSB = 0;
   localparam int ST_FULL = 3;
   localparam int ST_EMPTY = 4;
   localparam int ST_OVF = 5;

   // CTRL register, restart and ovf_clr clear themselves
   typedef struct packed {
      logic [WB_W-5:0] rsvd;
      logic            ovf_clr;
      logic            restart;
      logic            irq_en;
      logic            enable;
   } ctrl_word_t;

   // Write data seen as control word or as raw word holding a reload value
   typedef union packed {
      ctrl_word_t      ctrl;
      logic [WB_W-1:0] raw;
   } wb_word_u;

endpackage

`default_nettype wire
